// File: files.f
common/core_pkg.sv
common/exec_bus_if.sv
verilog/instr_fetch.sv
decode/register_file.sv
decode/decode_stage.sv
verilog/alu_stage.sv
verilog/riscv_core.sv
tb/riscv_core_assert.sv
tb/riscv_core_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module riscv_core_tb \
  -f files.f -o riscv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/riscv_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: tb/riscv_core_tb.sv
// Core testbench
`timescale 1ns/1ps

module riscv_core_tb;
  import core_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 5;
  localparam int ADDR_BITS    = 6;
  localparam int MEM_WORDS    = 2**ADDR_BITS;
  localparam int PIPE_DEPTH   = 4;
  // Rows from here on depend on no earlier row
  localparam int SECOND_START = 14;

  logic                 clock = 1'b0;
  logic                 i_reset;
  logic                 i_start;
  logic [ADDR_BITS-1:0] i_prog_address;
  logic [ADDR_BITS-1:0] i_isp_address;
  logic [XLEN-1:0]      i_isp_data;
  logic                 i_isp_write;
  logic [ADDR_BITS-1:0] o_current_pc;
  logic                 o_out_valid;
  logic [REG_BITS-1:0]  o_out_reg;
  logic [XLEN-1:0]      o_out_data;

  logic [XLEN-1:0]      row_word[$];
  bit                   row_reports[$];
  logic [REG_BITS-1:0]  row_reg[$];
  logic [XLEN-1:0]      row_value[$];
  logic [REG_BITS-1:0]  exp_reg[$];
  logic [XLEN-1:0]      exp_data[$];
  logic [ADDR_BITS-1:0] exp_pc[$];
  // PC seen on the last few falling edges, newest first
  logic [ADDR_BITS-1:0] pc_hist[PIPE_DEPTH] = '{default: '0};
  int                   value_errors = 0;
  int                   other_errors = 0;
  bit                   table_ready  = 1'b0;

  riscv_core #(
    .ADDRESS_BITS (ADDR_BITS)
  ) UUT (
    .clock          (clock),
    .i_reset        (i_reset),
    .i_start        (i_start),
    .i_prog_address (i_prog_address),
    .i_isp_address  (i_isp_address),
    .i_isp_data     (i_isp_data),
    .i_isp_write    (i_isp_write),
    .o_current_pc   (o_current_pc),
    .o_out_valid    (o_out_valid),
    .o_out_reg      (o_out_reg),
    .o_out_data     (o_out_data)
  );

  always #(CLK_PERIOD/2) clock = ~clock;

  // RV32I encodings for OP-IMM, OP and LUI
  function automatic logic [31:0] imm_instr(input int f3, input int rd, input int rs1,
                                            input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_instr(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] lui_instr(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  task automatic add_row(input logic [31:0] word, input bit reports, input int r,
                         input logic [31:0] value);
    row_word.push_back(word);
    row_reports.push_back(reports);
    row_reg.push_back(REG_BITS'(r));
    row_value.push_back(value);
  endtask

  task automatic build_table();
    add_row(imm_instr(0, 10, 0, 5), 1'b1, 10, 32'd5);
    add_row(imm_instr(0, 10, 10, 7), 1'b1, 10, 32'd12);
    add_row(reg_instr(0, 0, 11, 10, 10), 1'b1, 11, 32'd24);
    add_row(reg_instr(0, 0, 12, 10, 11), 1'b1, 12, 32'd36);
    add_row(imm_instr(4, 13, 12, 'h0f0), 1'b1, 13, 32'h0000_00d4);
    add_row(imm_instr(6, 14, 13, 'h700), 1'b1, 14, 32'h0000_07d4);
    add_row(imm_instr(7, 15, 14, 'h0f1), 1'b1, 15, 32'h0000_00d0);
    add_row(imm_instr(2, 16, 0, -1), 1'b1, 16, 32'd0);
    add_row(imm_instr(0, 5, 0, -8), 1'b0, 5, 32'hffff_fff8);
    add_row(imm_instr(2, 16, 5, 3), 1'b1, 16, 32'd1);
    add_row(imm_instr(1, 17, 16, 31), 1'b1, 17, 32'h8000_0000);
    add_row(imm_instr(5, 17, 17, 'h404), 1'b1, 17, 32'hf800_0000);
    // Write to x0 is dropped, then x0 reads back as zero
    add_row(imm_instr(0, 0, 10, 100), 1'b0, 0, 32'd0);
    add_row(reg_instr(0, 0, 10, 0, 0), 1'b1, 10, 32'd0);
    add_row(lui_instr(6, 'hfffff), 1'b0, 6, 32'hffff_f000);
    add_row(lui_instr(11, 'h12345), 1'b1, 11, 32'h1234_5000);
    add_row(reg_instr('h20, 0, 12, 11, 6), 1'b1, 12, 32'h1234_6000);
    add_row(reg_instr(0, 3, 13, 11, 6), 1'b1, 13, 32'd1);
    add_row(reg_instr(0, 2, 14, 11, 6), 1'b1, 14, 32'd0);
    add_row(reg_instr('h20, 5, 15, 6, 13), 1'b1, 15, 32'hffff_f800);
    add_row(reg_instr(0, 7, 16, 6, 12), 1'b1, 16, 32'h1234_6000);
    add_row(reg_instr(0, 0, 7, 6, 6), 1'b0, 7, 32'hffff_e000);
    add_row(reg_instr(0, 0, 17, 7, 0), 1'b1, 17, 32'hffff_e000);
    // All-zero word and a store, both no-ops here
    add_row(32'h0000_0000, 1'b0, 0, 32'd0);
    add_row(32'h00a1_2023, 1'b0, 0, 32'd0);
  endtask

  task automatic load_program();
    int addr;
    for (addr = 0; addr < MEM_WORDS; addr++) begin
      @(posedge clock);
      i_isp_write   <= 1'b1;
      i_isp_address <= ADDR_BITS'(addr);
      // Past the table an ADDI to x0 carrying the address
      i_isp_data    <= (addr < row_word.size()) ? row_word[addr] : imm_instr(0, 0, 0, addr);
    end
    @(posedge clock);
    i_isp_write <= 1'b0;
  endtask

  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      assert (o_out_valid == 1'b0) else begin
        value_errors++;
        $display("** Error at %0t ns: o_out_valid expected 0, got %b", $time, o_out_valid);
      end
    end
  endtask

  task automatic run_program(input int start_row);
    int row;
    int waited;
    int run_cycles;
    // Fetch runs to the top of memory, then the pipeline drains
    run_cycles = MEM_WORDS - start_row + PIPE_DEPTH + 2;
    for (row = start_row; row < row_word.size(); row++) begin
      if (row_reports[row]) begin
        exp_reg.push_back(row_reg[row]);
        exp_data.push_back(row_value[row]);
        exp_pc.push_back(ADDR_BITS'(row));
      end
    end
    @(posedge clock);
    i_start        <= 1'b1;
    i_prog_address <= ADDR_BITS'(start_row);
    @(posedge clock);
    i_start <= 1'b0;
    waited = 0;
    while (exp_reg.size() != 0 && waited < run_cycles) begin
      @(negedge clock);
      waited++;
    end
    assert (exp_reg.size() == 0) else begin
      other_errors++;
      $display("Run from address %0d ended with %0d results missing", start_row, exp_reg.size());
      exp_reg.delete();
      exp_data.delete();
      exp_pc.delete();
    end
    while (waited < run_cycles) begin
      @(negedge clock);
      waited++;
    end
  endtask

  // Results compared in program order
  always @(negedge clock) begin
    if (!i_reset && o_out_valid) begin
      assert (exp_reg.size() != 0) else begin
        other_errors++;
        $display("Unexpected result at %0t ns: x%0d = 0x%08h while none was pending",
                 $time, o_out_reg, o_out_data);
      end
      if (exp_reg.size() != 0) begin
        assert (o_out_reg == exp_reg[0]) else begin
          value_errors++;
          $display("** Error at %0t ns: o_out_reg expected %0d, got %0d",
                   $time, exp_reg[0], o_out_reg);
        end
        assert (o_out_data == exp_data[0]) else begin
          value_errors++;
          $display("** Error at %0t ns: o_out_data expected 0x%08h, got 0x%08h",
                   $time, exp_data[0], o_out_data);
        end
        // Result leaves four cycles after its word was addressed
        assert (pc_hist[PIPE_DEPTH-1] == exp_pc[0]) else begin
          value_errors++;
          $display("** Error at %0t ns: o_current_pc four cycles earlier expected %0d, got %0d",
                   $time, exp_pc[0], pc_hist[PIPE_DEPTH-1]);
        end
        void'(exp_reg.pop_front());
        void'(exp_data.pop_front());
        void'(exp_pc.pop_front());
      end
    end
    for (int i = PIPE_DEPTH-1; i > 0; i--) begin
      pc_hist[i] = pc_hist[i-1];
    end
    pc_hist[0] = o_current_pc;
  end

  // Watchdog sized from memory depth and table length
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (MEM_WORDS + row_word.size() + 20) * 3 * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout after %0d ns, the runs never completed", limit_ns);
    $display("Something failed");
    $finish;
  end

  initial begin
    i_reset        <= 1'b1;
    i_start        <= 1'b0;
    i_prog_address <= '0;
    i_isp_address  <= '0;
    i_isp_data     <= '0;
    i_isp_write    <= 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    i_reset <= 1'b0;
    load_program();
    // Program loaded but never started
    check_idle(2 * PIPE_DEPTH);
    run_program(0);
    run_program(SECOND_START);
    $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: tb/riscv_core_assert.sv
// Output port assertions
`timescale 1ns/1ps

module riscv_core_assert (
  input logic                          clock,
  input logic                          i_reset,
  input logic                          i_out_valid,
  input logic [core_pkg::REG_BITS-1:0] i_out_reg
);
  import core_pkg::*;

  logic [2:0] cycles_out_of_reset;

  // Saturating count of cycles since reset was released
  always_ff @(posedge clock) begin
    if (i_reset) begin
      cycles_out_of_reset <= '0;
    end else if (cycles_out_of_reset != 3'd7) begin
      cycles_out_of_reset <= cycles_out_of_reset + 3'd1;
    end
  end

  valid_known: assert property (@(posedge clock) disable iff (i_reset)
    !$isunknown(i_out_valid))
    else $error("o_out_valid is unknown");

  reg_in_range: assert property (@(posedge clock) disable iff (i_reset)
    i_out_valid |-> (i_out_reg >= REG_BITS'(REPORT_REG_FIRST)) &&
                    (i_out_reg <= REG_BITS'(REPORT_REG_LAST)))
    else $error("o_out_reg %0d lies outside the reported range", i_out_reg);

  quiet_after_reset: assert property (@(posedge clock) disable iff (i_reset)
    (cycles_out_of_reset < 3'd4) |-> !i_out_valid)
    else $error("Result strobe within four cycles of reset release");

endmodule

bind riscv_core riscv_core_assert output_checks (
  .clock       (clock),
  .i_reset     (i_reset),
  .i_out_valid (o_out_valid),
  .i_out_reg   (o_out_reg)
);

// File: verilog/riscv_core.sv
// Four-stage integer core
`timescale 1ns/1ps

module riscv_core #(
  parameter int ADDRESS_BITS = 6
) (
  input  logic                          clock,
  input  logic                          i_reset,
  input  logic                          i_start,
  input  logic [ADDRESS_BITS-1:0]       i_prog_address,
  input  logic [ADDRESS_BITS-1:0]       i_isp_address,
  input  logic [core_pkg::XLEN-1:0]     i_isp_data,
  input  logic                          i_isp_write,
  output logic [ADDRESS_BITS-1:0]       o_current_pc,
  output logic                          o_out_valid,
  output logic [core_pkg::REG_BITS-1:0] o_out_reg,
  output logic [core_pkg::XLEN-1:0]     o_out_data
);
  import core_pkg::*;

  logic [XLEN-1:0]     instr;
  logic                instr_valid;
  logic                wb_write;
  logic [REG_BITS-1:0] wb_reg;
  logic [XLEN-1:0]     wb_data;
  logic                report_hit;

  exec_bus_if ex_bus ();

  instr_fetch #(
    .ADDRESS_BITS (ADDRESS_BITS)
  ) fetch (
    .clock          (clock),
    .i_reset        (i_reset),
    .i_start        (i_start),
    .i_prog_address (i_prog_address),
    .i_isp_address  (i_isp_address),
    .i_isp_data     (i_isp_data),
    .i_isp_write    (i_isp_write),
    .o_pc           (o_current_pc),
    .o_instr        (instr),
    .o_instr_valid  (instr_valid)
  );

  decode_stage decode (
    .clock         (clock),
    .i_reset       (i_reset),
    .i_instr       (instr),
    .i_instr_valid (instr_valid),
    .i_wb_write    (wb_write),
    .i_wb_reg      (wb_reg),
    .i_wb_data     (wb_data),
    .bus           (ex_bus)
  );

  alu_stage execute (
    .clock      (clock),
    .i_reset    (i_reset),
    .bus        (ex_bus),
    .o_wb_write (wb_write),
    .o_wb_reg   (wb_reg),
    .o_wb_data  (wb_data)
  );

  // Only a0..a7 leave the core
  assign report_hit = wb_write && (wb_reg >= REPORT_REG_FIRST) && (wb_reg <= REPORT_REG_LAST);

  always_ff @(posedge clock) begin
    if (i_reset) begin
      o_out_valid <= 1'b0;
    end else begin
      o_out_valid <= report_hit;
    end
    if (report_hit) begin
      o_out_reg  <= wb_reg;
      o_out_data <= wb_data;
    end
  end

endmodule

// File: verilog/alu_stage.sv
// Execute stage with operand bypass
`timescale 1ns/1ps

module alu_stage (
  input  logic                          clock,
  input  logic                          i_reset,
  exec_bus_if.execute                   bus,
  output logic                          o_wb_write,
  output logic [core_pkg::REG_BITS-1:0] o_wb_reg,
  output logic [core_pkg::XLEN-1:0]     o_wb_data
);
  import core_pkg::*;

  logic            hit_a;
  logic            hit_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [4:0]      shamt;
  logic [XLEN-1:0] result;

  // Previous instruction result still sits in the writeback register
  assign hit_a = o_wb_write && (o_wb_reg != '0) && (o_wb_reg == bus.rs1);
  assign hit_b = o_wb_write && (o_wb_reg != '0) && (o_wb_reg == bus.rs2);

  assign op_a  = hit_a ? o_wb_data : bus.op_a;
  assign op_b  = (bus.b_is_reg && hit_b) ? o_wb_data : bus.op_b;
  assign shamt = op_b[4:0];

  always_comb begin
    case (bus.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      default:    result = op_b;
    endcase
  end

  // Execute/writeback register
  always_ff @(posedge clock) begin
    if (i_reset) begin
      o_wb_write <= 1'b0;
    end else begin
      o_wb_write <= bus.valid && bus.reg_write;
    end
    o_wb_reg  <= bus.rd;
    o_wb_data <= result;
  end

endmodule

// File: decode/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ps

module decode_stage (
  input  logic                          clock,
  input  logic                          i_reset,
  input  logic [core_pkg::XLEN-1:0]     i_instr,
  input  logic                          i_instr_valid,
  input  logic                          i_wb_write,
  input  logic [core_pkg::REG_BITS-1:0] i_wb_reg,
  input  logic [core_pkg::XLEN-1:0]     i_wb_data,
  exec_bus_if.decode                    bus
);
  import core_pkg::*;

  opcode_e             opcode;
  logic [REG_BITS-1:0] rd;
  logic [REG_BITS-1:0] rs1;
  logic [REG_BITS-1:0] rs2;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [XLEN-1:0]     imm_i;
  logic [XLEN-1:0]     imm_u;
  logic [XLEN-1:0]     rs1_data;
  logic [XLEN-1:0]     rs2_data;
  alu_op_e             alu_op;
  logic                reg_write;
  logic                b_is_reg;
  logic [XLEN-1:0]     op_b;

  // Shared funct3 map, alt selects SUB and SRA
  function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt_sub,
                                        input logic alt_sra);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt_sub ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_sra ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(i_instr[6:0]);
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign rs1    = i_instr[19:15];
  assign rs2    = i_instr[24:20];
  assign funct7 = i_instr[31:25];
  assign imm_i  = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_u  = {i_instr[31:12], 12'b0};

  register_file regs (
    .clock      (clock),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_write    (i_wb_write),
    .i_wr_reg   (i_wb_reg),
    .i_wr_data  (i_wb_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  always_comb begin
    alu_op    = ALU_ADD;
    reg_write = 1'b0;
    b_is_reg  = 1'b0;
    op_b      = imm_i;
    case (opcode)
      OPC_OP_IMM: begin
        alu_op    = funct3_op(funct3, 1'b0, funct7[5]);
        reg_write = 1'b1;
      end
      OPC_OP: begin
        alu_op    = funct3_op(funct3, funct7[5], funct7[5]);
        reg_write = 1'b1;
        b_is_reg  = 1'b1;
        op_b      = rs2_data;
      end
      OPC_LUI: begin
        alu_op    = ALU_PASS_B;
        reg_write = 1'b1;
        op_b      = imm_u;
      end
      // Anything else runs through as a no-op
      default: reg_write = 1'b0;
    endcase
    if (rd == '0) begin
      reg_write = 1'b0;
    end
  end

  // Decode/execute register
  always_ff @(posedge clock) begin
    if (i_reset) begin
      bus.valid <= 1'b0;
    end else begin
      bus.valid <= i_instr_valid;
    end
    bus.alu_op    <= alu_op;
    bus.rd        <= rd;
    bus.rs1       <= rs1;
    bus.rs2       <= rs2;
    bus.reg_write <= reg_write;
    bus.b_is_reg  <= b_is_reg;
    bus.op_a      <= rs1_data;
    bus.op_b      <= op_b;
  end

endmodule

// File: decode/register_file.sv
// Integer register file
`timescale 1ns/1ps

module register_file (
  input  logic                          clock,
  input  logic [core_pkg::REG_BITS-1:0] i_rs1,
  input  logic [core_pkg::REG_BITS-1:0] i_rs2,
  input  logic                          i_write,
  input  logic [core_pkg::REG_BITS-1:0] i_wr_reg,
  input  logic [core_pkg::XLEN-1:0]     i_wr_data,
  output logic [core_pkg::XLEN-1:0]     o_rs1_data,
  output logic [core_pkg::XLEN-1:0]     o_rs2_data
);
  import core_pkg::*;

  // x1..x31 only, x0 has no storage
  logic [XLEN-1:0] regs [1:31];

  function automatic logic [XLEN-1:0] read_port(input logic [REG_BITS-1:0] idx);
    logic [XLEN-1:0] value;
    if (idx == '0) begin
      value = '0;
    end else if (i_write && (i_wr_reg == idx)) begin
      // Same-cycle write goes straight through
      value = i_wr_data;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_ff @(posedge clock) begin
    if (i_write && (i_wr_reg != '0)) begin
      regs[i_wr_reg] <= i_wr_data;
    end
  end

  always_comb begin
    o_rs1_data = read_port(i_rs1);
    o_rs2_data = read_port(i_rs2);
  end

endmodule

// File: verilog/instr_fetch.sv
// Instruction fetch unit
`timescale 1ns/1ps

module instr_fetch #(
  parameter int ADDRESS_BITS = 6
) (
  input  logic                      clock,
  input  logic                      i_reset,
  input  logic                      i_start,
  input  logic [ADDRESS_BITS-1:0]   i_prog_address,
  input  logic [ADDRESS_BITS-1:0]   i_isp_address,
  input  logic [core_pkg::XLEN-1:0] i_isp_data,
  input  logic                      i_isp_write,
  output logic [ADDRESS_BITS-1:0]   o_pc,
  output logic [core_pkg::XLEN-1:0] o_instr,
  output logic                      o_instr_valid
);
  import core_pkg::*;

  localparam logic [ADDRESS_BITS-1:0] LAST_ADDRESS = '1;

  logic [XLEN-1:0] prog_mem [2**ADDRESS_BITS];
  logic            running;

  // Programmer writes and synchronous read of the word at the PC
  always_ff @(posedge clock) begin
    if (i_isp_write) begin
      prog_mem[i_isp_address] <= i_isp_data;
    end
    o_instr <= prog_mem[o_pc];
  end

  // Run control
  always_ff @(posedge clock) begin
    if (i_reset) begin
      o_pc          <= '0;
      running       <= 1'b0;
      o_instr_valid <= 1'b0;
    end else begin
      o_instr_valid <= running;
      if (i_start) begin
        o_pc    <= i_prog_address;
        running <= 1'b1;
      end else if (running) begin
        o_pc <= o_pc + 1'b1;
        // Stop once the top word has been fetched
        if (o_pc == LAST_ADDRESS) begin
          running <= 1'b0;
        end
      end
    end
  end

endmodule

// File: common/exec_bus_if.sv
// Decode to execute bus
`timescale 1ns/1ps

interface exec_bus_if;
  import core_pkg::*;

  logic                valid;
  alu_op_e             alu_op;
  logic [REG_BITS-1:0] rd;
  logic [REG_BITS-1:0] rs1;
  logic [REG_BITS-1:0] rs2;
  logic                reg_write;
  // Operand B comes from rs2 rather than an immediate
  logic                b_is_reg;
  logic [XLEN-1:0]     op_a;
  logic [XLEN-1:0]     op_b;

  modport decode (
    output valid, alu_op, rd, rs1, rs2, reg_write, b_is_reg, op_a, op_b
  );

  modport execute (
    input valid, alu_op, rd, rs1, rs2, reg_write, b_is_reg, op_a, op_b
  );

endinterface

// File: common/core_pkg.sv
// Core shared definitions
package core_pkg;

  // Data path and register index widths
  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  // Major opcodes handled by the pipeline
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // ALU operations selected in decode
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // LUI result is the U-type immediate on operand B
    ALU_PASS_B
  } alu_op_e;

  // Writes to a0..a7 go out on the peripheral port
  localparam int REPORT_REG_FIRST = 10;
  localparam int REPORT_REG_LAST  = 17;

endpackage
